// File: shaPkg.sv
`default_nettype none

package shaPkg;

  typedef logic [31:0] word_t;

  // Word 0 sits in the most significant slice, as in the FIPS byte order
  typedef word_t [0:7] digest_t;
  typedef word_t [0:15] block_t;

  localparam int RoundCount = 64;

  localparam word_t [0:RoundCount-1] RoundK = {
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Chaining value for the first block of every message
  localparam digest_t InitHash = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

endpackage

`default_nettype wire

// File: minerPkg.sv
`default_nettype none

package minerPkg;

  localparam int DefMaxBlocks = 4;
  localparam int BlockWords = 16;

  // Byte addresses on the APB side
  localparam int AddrWidth = 12;
  localparam int WordIdxBits = 6;

  localparam logic [AddrWidth-1:0] AddrBlocks = 12'h100;
  localparam logic [AddrWidth-1:0] AddrDifficulty = 12'h104;
  localparam logic [AddrWidth-1:0] AddrStart = 12'h108;
  localparam logic [AddrWidth-1:0] AddrStatus = 12'h10C;
  localparam logic [AddrWidth-1:0] AddrNonce = 12'h110;
  localparam logic [AddrWidth-1:0] AddrDigest = 12'h120;

  // Leading zeros of a 256-bit digest, 0 to 256
  typedef logic [8:0] zeroCount_t;

  // Width of a block index for a store of maxBlocks blocks
  function automatic int blockIdxBits(int maxBlocks);
    return (maxBlocks > 1) ? $clog2(maxBlocks) : 1;
  endfunction

  function automatic int blockCountBits(int maxBlocks);
    return $clog2(maxBlocks + 1);
  endfunction

endpackage

`default_nettype wire

// File: hashIf.sv
`default_nettype none

// One block compression between the search FSM and the SHA-256 core
interface hashIf;
  logic start;
  shaPkg::block_t block;
  shaPkg::digest_t chainIn;
  logic done;
  shaPkg::digest_t digest;

  modport requester (output start, block, chainIn, input done, digest);
  modport core (input start, block, chainIn, output done, digest);
endinterface

`default_nettype wire

// File: minerCtrlIf.sv
`default_nettype none

// Job settings from the host side and search status back
interface minerCtrlIf #(
  parameter int MaxBlocks = minerPkg::DefMaxBlocks
);
  logic start;
  logic [minerPkg::blockCountBits(MaxBlocks)-1:0] blockCount;
  minerPkg::zeroCount_t difficulty;
  logic busy;
  logic found;
  shaPkg::word_t nonce;
  shaPkg::digest_t digest;

  modport host (output start, blockCount, difficulty, input busy, found, nonce, digest);
  modport search (input start, blockCount, difficulty, output busy, found, nonce, digest);
endinterface

`default_nettype wire

// File: hostPort.sv
`default_nettype none

module hostPort #(
  parameter int MaxBlocks = minerPkg::DefMaxBlocks
) (
  input  logic                           clk,
  input  logic                           block_load,
  input  logic [minerPkg::AddrWidth-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  shaPkg::word_t                  pwdata,
  output shaPkg::word_t                  prdata,
  output logic                           pready,
  minerCtrlIf.host                       ctrl,
  output logic                           wrEn,
  output logic [minerPkg::WordIdxBits-1:0] wrAddr,
  output shaPkg::word_t                  wrData
);

  localparam int CountBits = minerPkg::blockCountBits(MaxBlocks);
  localparam int TopBit = minerPkg::AddrWidth - 1;

  logic access;
  logic hostWrite;
  logic inBlockRegion;
  logic [CountBits-1:0] blockCount;
  minerPkg::zeroCount_t difficulty;

  assign pready = 1'b1;
  assign access = psel && penable;

  // Nothing the search depends on may change while it runs
  assign hostWrite = access && pwrite && !ctrl.busy;

  assign wrAddr = paddr[minerPkg::WordIdxBits+1:2];
  assign wrData = pwdata;
  assign inBlockRegion = paddr < minerPkg::AddrBlocks;
  assign wrEn = hostWrite && inBlockRegion
             && (int'(wrAddr) < MaxBlocks * minerPkg::BlockWords);

  assign ctrl.start = hostWrite && (paddr == minerPkg::AddrStart);
  assign ctrl.blockCount = blockCount;
  assign ctrl.difficulty = difficulty;

  always_ff @(posedge clk or negedge block_load) begin
    if (!block_load) begin
      blockCount <= CountBits'(1);
      difficulty <= '0;
    end else if (hostWrite) begin
      if (paddr == minerPkg::AddrBlocks)
        blockCount <= pwdata[CountBits-1:0];
      if (paddr == minerPkg::AddrDifficulty)
        difficulty <= pwdata[$bits(minerPkg::zeroCount_t)-1:0];
    end
  end

  // Read mux, zero on unmapped addresses
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (paddr[TopBit:5] == minerPkg::AddrDigest[TopBit:5]) begin
        prdata = ctrl.digest[paddr[4:2]];
      end else begin
        case (paddr)
          minerPkg::AddrBlocks:     prdata = shaPkg::word_t'(blockCount);
          minerPkg::AddrDifficulty: prdata = shaPkg::word_t'(difficulty);
          minerPkg::AddrStatus:     prdata = {30'b0, ctrl.found, ctrl.busy};
          minerPkg::AddrNonce:      prdata = ctrl.nonce;
          default:                  prdata = '0;
        endcase
      end
    end
  end

  // The search walks exactly this many stored blocks
  assert property (@(posedge clk) disable iff (!block_load)
    hostWrite && (paddr == minerPkg::AddrBlocks)
      |-> (pwdata >= 1) && (pwdata <= MaxBlocks))
    else $error("block count %0d outside 1..%0d", pwdata, MaxBlocks);

endmodule

`default_nettype wire

// File: blockStore.sv
`default_nettype none

module blockStore #(
  parameter int MaxBlocks = minerPkg::DefMaxBlocks
) (
  input  logic                                            clk,
  input  logic                                            wrEn,
  input  logic [minerPkg::WordIdxBits-1:0]                wrAddr,
  input  shaPkg::word_t                                   wrData,
  input  logic [minerPkg::blockIdxBits(MaxBlocks)-1:0]    rdIndex,
  output shaPkg::block_t                                  rdBlock
);

  localparam int WordBits = $clog2(minerPkg::BlockWords);

  shaPkg::block_t mem [MaxBlocks];

  // Word writes from the host, whole-block reads for the hash
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrAddr[minerPkg::WordIdxBits-1:WordBits]][wrAddr[WordBits-1:0]] <= wrData;
    end
    rdBlock <= mem[rdIndex];
  end

  // Host decode must keep writes inside the populated blocks
  assert property (@(posedge clk)
    wrEn |-> int'(wrAddr) < MaxBlocks * minerPkg::BlockWords)
    else $error("block write to word %0d beyond %0d blocks", wrAddr, MaxBlocks);

endmodule

`default_nettype wire

// File: nonceSearch.sv
`default_nettype none

module nonceSearch #(
  parameter int MaxBlocks = minerPkg::DefMaxBlocks
) (
  input  logic                                         clk,
  input  logic                                         block_load,
  minerCtrlIf.search                                   ctrl,
  hashIf.requester                                     hash,
  output logic [minerPkg::blockIdxBits(MaxBlocks)-1:0] rdIndex,
  input  shaPkg::block_t                               rdBlock
);

  localparam int IdxBits = minerPkg::blockIdxBits(MaxBlocks);
  localparam int CountBits = minerPkg::blockCountBits(MaxBlocks);

  typedef enum logic [2:0] {Idle, Seed, Read, Launch, Compress, Check} state_t;

  state_t state;
  logic [IdxBits-1:0] blkIdx;
  logic [CountBits-1:0] blocksDone;
  logic firstBlock;
  logic lastBlock;
  logic busy;
  logic found;
  shaPkg::word_t nonce;
  minerPkg::zeroCount_t zeros;

  function automatic minerPkg::zeroCount_t leadingZeros(shaPkg::digest_t d);
    logic [255:0] bits;
    logic seen;
    minerPkg::zeroCount_t n;
    bits = d;
    seen = 1'b0;
    n = '0;
    for (int i = 255; i >= 0; i--) begin
      if (bits[i])
        seen = 1'b1;
      if (!seen)
        n = n + 1'b1;
    end
    return n;
  endfunction

  // blkIdx rests at 0 outside a try, so the store keeps reading block 0
  assign rdIndex = blkIdx;
  assign firstBlock = (blkIdx == '0);
  assign blocksDone = CountBits'(blkIdx) + 1'b1;
  assign lastBlock = (blocksDone == ctrl.blockCount);
  assign zeros = leadingZeros(hash.digest);

  assign hash.start = (state == Launch);
  assign hash.chainIn = firstBlock ? shaPkg::InitHash : hash.digest;

  // Nonce replaces the first message word of block 0
  always_comb begin
    hash.block = rdBlock;
    if (firstBlock)
      hash.block[0] = nonce;
  end

  assign ctrl.busy = busy;
  assign ctrl.found = found;
  assign ctrl.nonce = nonce;
  assign ctrl.digest = hash.digest;

  always_ff @(posedge clk or negedge block_load) begin
    if (!block_load) begin
      state <= Idle;
      blkIdx <= '0;
      busy <= 1'b0;
      found <= 1'b0;
      nonce <= '0;
    end else begin
      case (state)
        Idle: begin
          if (ctrl.start) begin
            busy <= 1'b1;
            found <= 1'b0;
            state <= Seed;
          end
        end
        // Stored word 0 of block 0 is the first nonce
        Seed: begin
          nonce <= rdBlock[0];
          state <= Read;
        end
        Read: state <= Launch;
        Launch: state <= Compress;
        Compress: begin
          if (hash.done) begin
            if (lastBlock) begin
              state <= Check;
            end else begin
              blkIdx <= blkIdx + 1'b1;
              state <= Read;
            end
          end
        end
        Check: begin
          blkIdx <= '0;
          if (zeros >= ctrl.difficulty) begin
            found <= 1'b1;
            busy <= 1'b0;
            state <= Idle;
          end else begin
            nonce <= nonce + 1'b1;
            state <= Read;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!block_load) !(ctrl.found && ctrl.busy))
    else $error("found and busy high together");

endmodule

`default_nettype wire

// File: sha256Core.sv
`default_nettype none

module sha256Core (
  input logic clk,
  input logic block_load,
  hashIf.core hash
);

  localparam int RoundBits = $clog2(shaPkg::RoundCount);
  localparam logic [RoundBits-1:0] LastRound = RoundBits'(shaPkg::RoundCount - 1);

  logic running;
  logic addBack;
  logic [RoundBits-1:0] round;

  // vars holds a..h, window holds W[t] .. W[t+15]
  shaPkg::digest_t vars;
  shaPkg::digest_t chain;
  shaPkg::block_t window;
  shaPkg::word_t t1;
  shaPkg::word_t t2;
  shaPkg::word_t nextW;

  function automatic shaPkg::word_t rotr(shaPkg::word_t x, int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic shaPkg::word_t bigSigma0(shaPkg::word_t x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic shaPkg::word_t bigSigma1(shaPkg::word_t x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic shaPkg::word_t smallSigma0(shaPkg::word_t x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic shaPkg::word_t smallSigma1(shaPkg::word_t x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  function automatic shaPkg::word_t choose(shaPkg::word_t x, shaPkg::word_t y,
                                           shaPkg::word_t z);
    return (x & y) ^ (~x & z);
  endfunction

  function automatic shaPkg::word_t majority(shaPkg::word_t x, shaPkg::word_t y,
                                             shaPkg::word_t z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

  always_comb begin
    t1 = vars[7] + bigSigma1(vars[4]) + choose(vars[4], vars[5], vars[6])
       + shaPkg::RoundK[round] + window[0];
    t2 = bigSigma0(vars[0]) + majority(vars[0], vars[1], vars[2]);
    // Schedule word W[t+16] from the current window
    nextW = smallSigma1(window[14]) + window[9] + smallSigma0(window[1]) + window[0];
  end

  // Load, 64 rounds, add-back, then done one cycle later
  always_ff @(posedge clk or negedge block_load) begin
    if (!block_load) begin
      running <= 1'b0;
      addBack <= 1'b0;
      round <= '0;
      hash.done <= 1'b0;
    end else begin
      hash.done <= addBack;
      addBack <= running && (round == LastRound);
      if (hash.start) begin
        running <= 1'b1;
        round <= '0;
      end else if (running) begin
        round <= round + 1'b1;
        if (round == LastRound)
          running <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hash.start) begin
      vars <= hash.chainIn;
      chain <= hash.chainIn;
      window <= hash.block;
    end else if (running) begin
      vars <= {t1 + t2, vars[0], vars[1], vars[2], vars[3] + t1, vars[4], vars[5], vars[6]};
      window <= {window[1:15], nextW};
    end else if (addBack) begin
      for (int i = 0; i < 8; i++) begin
        hash.digest[i] <= chain[i] + vars[i];
      end
    end
  end

  // The requester must wait for done before the next block
  assert property (@(posedge clk) disable iff (!block_load)
    hash.start |-> !running && !addBack)
    else $error("compression start during a running block");

endmodule

`default_nettype wire

// File: minerTop.sv
`default_nettype none

module minerTop #(
  parameter int MaxBlocks = minerPkg::DefMaxBlocks
) (
  input  logic                           clk,
  input  logic                           block_load,
  input  logic [minerPkg::AddrWidth-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready
);

  logic wrEn;
  logic [minerPkg::WordIdxBits-1:0] wrAddr;
  shaPkg::word_t wrData;
  logic [minerPkg::blockIdxBits(MaxBlocks)-1:0] rdIndex;
  shaPkg::block_t rdBlock;

  minerCtrlIf #(.MaxBlocks(MaxBlocks)) ctrlBus ();
  hashIf hashBus ();

  hostPort #(.MaxBlocks(MaxBlocks)) host0 (
    .clk        (clk),
    .block_load (block_load),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .ctrl       (ctrlBus.host),
    .wrEn       (wrEn),
    .wrAddr     (wrAddr),
    .wrData     (wrData)
  );

  blockStore #(.MaxBlocks(MaxBlocks)) store0 (
    .clk     (clk),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .rdIndex (rdIndex),
    .rdBlock (rdBlock)
  );

  nonceSearch #(.MaxBlocks(MaxBlocks)) search0 (
    .clk        (clk),
    .block_load (block_load),
    .ctrl       (ctrlBus.search),
    .hash       (hashBus.requester),
    .rdIndex    (rdIndex),
    .rdBlock    (rdBlock)
  );

  sha256Core core0 (
    .clk        (clk),
    .block_load (block_load),
    .hash       (hashBus.core)
  );

endmodule

`default_nettype wire

// File: minerModel.svh
`ifndef MINER_MODEL_SVH
`define MINER_MODEL_SVH

// Upper bound on tries so a bad difficulty cannot stall the model
localparam int MaxTries = 65536;

function automatic logic [31:0] rotateRight(logic [31:0] x, int n);
  return (x >> n) | (x << (32 - n));
endfunction

// FIPS 180-4 compression with the full 64-word schedule
function automatic logic [255:0] compressBlock(logic [255:0] h, logic [511:0] m);
  logic [31:0] w [64];
  logic [31:0] v [8];
  logic [31:0] s0;
  logic [31:0] s1;
  logic [31:0] tmp1;
  logic [31:0] tmp2;
  logic [255:0] result;
  for (int t = 0; t < 16; t++)
    w[t] = m[511 - 32 * t -: 32];
  for (int t = 16; t < 64; t++) begin
    s0 = rotateRight(w[t-15], 7) ^ rotateRight(w[t-15], 18) ^ (w[t-15] >> 3);
    s1 = rotateRight(w[t-2], 17) ^ rotateRight(w[t-2], 19) ^ (w[t-2] >> 10);
    w[t] = w[t-16] + s0 + w[t-7] + s1;
  end
  for (int i = 0; i < 8; i++)
    v[i] = h[255 - 32 * i -: 32];
  for (int t = 0; t < 64; t++) begin
    s1 = rotateRight(v[4], 6) ^ rotateRight(v[4], 11) ^ rotateRight(v[4], 25);
    tmp1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + shaPkg::RoundK[t] + w[t];
    s0 = rotateRight(v[0], 2) ^ rotateRight(v[0], 13) ^ rotateRight(v[0], 22);
    tmp2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
    for (int i = 7; i > 0; i--)
      v[i] = v[i-1];
    v[4] = v[4] + tmp1;
    v[0] = tmp1 + tmp2;
  end
  for (int i = 0; i < 8; i++)
    result[255 - 32 * i -: 32] = h[255 - 32 * i -: 32] + v[i];
  return result;
endfunction

// One try over one or two blocks, nonce in word 0 of block 0
function automatic logic [255:0] hashJob(logic [511:0] b0, logic [511:0] b1, int count,
                                         logic [31:0] nonce);
  logic [511:0] first;
  logic [255:0] h;
  first = b0;
  first[511:480] = nonce;
  h = compressBlock(shaPkg::InitHash, first);
  if (count > 1)
    h = compressBlock(h, b1);
  return h;
endfunction

function automatic int zeroRun(logic [255:0] d);
  int n;
  n = 0;
  while (n < 256 && !d[255 - n])
    n++;
  return n;
endfunction

// First nonce from the stored seed word upward that meets the difficulty
task automatic findNonce(input logic [511:0] b0, input logic [511:0] b1, input int count,
                         input int difficulty, output logic [31:0] nonce,
                         output logic [255:0] digest, output int tries);
  nonce = b0[511:480];
  tries = 1;
  digest = hashJob(b0, b1, count, nonce);
  while (zeroRun(digest) < difficulty && tries < MaxTries) begin
    nonce = nonce + 1;
    tries++;
    digest = hashJob(b0, b1, count, nonce);
  end
endtask

`endif

// File: minerTb.sv
`default_nettype none

module minerTb;

  localparam int Seed = 72;
  localparam int CyclesPerBlock = 68;
  localparam int TestSlack = 200;

  localparam logic [511:0] AbcBlock = {32'h61626380, {14{32'h0}}, 32'h00000018};
  localparam logic [255:0] AbcDigest =
    256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;
  localparam logic [511:0] LongBlock0 = {
    32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
    32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
    32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
    32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
  };
  localparam logic [511:0] LongBlock1 = {{15{32'h0}}, 32'h000001c0};
  localparam logic [255:0] LongDigest =
    256'h248d6a61_d20638b8_e5c02693_0c3e6039_a33ce459_64ff2167_f6ecedd4_19db06c1;

  logic clk = 1'b0;
  logic block_load;
  logic [minerPkg::AddrWidth-1:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;

  int errors = 0;
  int checks = 0;
  int testErrors = 0;
  int testCount = 0;
  int cycles = 0;
  int cycleLimit = 100000;
  string testName = "init";

  logic [511:0] randBlock;
  logic [31:0] randNonce;
  logic [255:0] randDigest;
  int randTries;
  logic [31:0] easyNonce;
  logic [255:0] easyDigest;
  int easyTries;

  `include "minerModel.svh"

  minerTop dut0 (
    .clk        (clk),
    .block_load (block_load),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic noteError();
    errors++;
    testErrors++;
  endtask

  task automatic checkWord(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      $display("FAIL %s %s: expected %h, actual %h", testName, what, expected, actual);
      noteError();
    end
  endtask

  // No wait states on this slave
  assert property (@(posedge clk) pready)
    else begin
      $display("FAIL %s pready: expected 1, actual %b", testName, $sampled(pready));
      noteError();
    end

  assert property (@(posedge clk) disable iff (!block_load)
    psel && penable && !pwrite && (paddr == minerPkg::AddrStatus) |-> prdata[1:0] != 2'b11)
    else begin
      $display("FAIL %s status: expected busy and found not both set, actual %h",
               testName, $sampled(prdata));
      noteError();
    end

  task automatic apbWrite(logic [minerPkg::AddrWidth-1:0] addr, logic [31:0] data);
    @(negedge clk);
    paddr = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  // Data is taken at the falling edge after the access cycle's rising edge
  task automatic apbRead(logic [minerPkg::AddrWidth-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    paddr = addr;
    pwrite = 1'b0;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic loadBlock(int b, logic [511:0] m);
    for (int w = 0; w < 16; w++)
      apbWrite(minerPkg::AddrWidth'((b * 16 + w) * 4), m[511 - 32 * w -: 32]);
  endtask

  task automatic startJob(int count, int difficulty);
    apbWrite(minerPkg::AddrBlocks, 32'(count));
    apbWrite(minerPkg::AddrDifficulty, 32'(difficulty));
    apbWrite(minerPkg::AddrStart, 32'h1);
  endtask

  // Busy from the first poll until the search reports found
  task automatic waitForResult();
    logic [31:0] status;
    apbRead(minerPkg::AddrStatus, status);
    checkWord("status after start", 32'h1, status);
    while (status[0]) begin
      apbRead(minerPkg::AddrStatus, status);
      assert (status == 32'h1 || status == 32'h2)
      else begin
        $display("FAIL %s status while waiting: expected 1 or 2, actual %h",
                 testName, status);
        noteError();
      end
    end
    checkWord("final status", 32'h2, status);
  endtask

  task automatic checkResult(logic [31:0] expNonce, logic [255:0] expDigest);
    logic [31:0] value;
    apbRead(minerPkg::AddrNonce, value);
    checkWord("nonce", expNonce, value);
    for (int i = 0; i < 8; i++) begin
      apbRead(minerPkg::AddrDigest + minerPkg::AddrWidth'(4 * i), value);
      checkWord($sformatf("digest word %0d", i), expDigest[255 - 32 * i -: 32], value);
    end
  endtask

  task automatic startTest(string name);
    testName = name;
    testErrors = 0;
  endtask

  task automatic finishTest();
    testCount++;
    if (testErrors == 0)
      $display("test %0d %s: ok", testCount, testName);
    else
      $display("test %0d %s: %0d errors", testCount, testName, testErrors);
  endtask

  initial begin
    logic [31:0] value;
    void'($urandom(Seed));
    block_load = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    for (int w = 0; w < 16; w++)
      randBlock[511 - 32 * w -: 32] = $urandom();
    findNonce(randBlock, '0, 1, 6, randNonce, randDigest, randTries);
    findNonce(randBlock, '0, 1, 4, easyNonce, easyDigest, easyTries);
    // Each try costs blocks x 68 cycles plus the check cycle
    cycleLimit = 5 * TestSlack + (CyclesPerBlock + 1) + (2 * CyclesPerBlock + 1)
               + (2 * randTries + easyTries) * (CyclesPerBlock + 1);

    startTest("reset");
    repeat (4) @(negedge clk);
    block_load = 1'b1;
    apbRead(minerPkg::AddrStatus, value);
    checkWord("status", 32'h0, value);
    checkWord("pready", 32'h1, {31'b0, pready});
    finishTest();

    startTest("abc");
    loadBlock(0, AbcBlock);
    startJob(1, 0);
    waitForResult();
    checkResult(32'h61626380, AbcDigest);
    finishTest();

    startTest("twoBlocks");
    loadBlock(0, LongBlock0);
    loadBlock(1, LongBlock1);
    startJob(2, 0);
    waitForResult();
    checkResult(32'h61626364, LongDigest);
    finishTest();

    startTest("search");
    loadBlock(0, randBlock);
    startJob(1, 6);
    waitForResult();
    checkResult(randNonce, randDigest);
    finishTest();

    // Rerun at difficulty 6 while the writes below land during busy and get dropped
    startTest("busyWrites");
    apbWrite(minerPkg::AddrStart, 32'h1);
    apbWrite(12'h000, ~randBlock[511:480]);
    apbWrite(12'h014, $urandom());
    apbWrite(minerPkg::AddrStart, 32'h1);
    waitForResult();
    checkResult(randNonce, randDigest);
    startJob(1, 4);
    waitForResult();
    checkResult(easyNonce, easyDigest);
    finishTest();

    $display("tests %0d, checks %0d, errors %0d", testCount, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
shaPkg.sv
minerPkg.sv
hashIf.sv
minerCtrlIf.sv
hostPort.sv
blockStore.sv
nonceSearch.sv
sha256Core.sv
minerTop.sv
minerTb.sv

// File: Bender.yml
package:
  name: miner_core

sources:
  - files:
      - shaPkg.sv
      - minerPkg.sv
      - hashIf.sv
      - minerCtrlIf.sv
      - hostPort.sv
      - blockStore.sv
      - nonceSearch.sv
      - sha256Core.sv
      - minerTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - minerTb.sv
